/* hw/debug_overlay_params.svh */
`ifndef DEBUG_OVERLAY_PARAMS_SVH
`define DEBUG_OVERLAY_PARAMS_SVH

// displayed value and its decimal form.
`define DOV_VALUE_WIDTH 16
`define DOV_DIGITS      5

// glyphs are square, one bit per pixel.
`define DOV_GLYPH_W     8

// raster pixel fields.
`define DOV_PIXEL_WIDTH 12
`define DOV_COORD_WIDTH 11

// top-left corner of the overlay box.
`define DOV_BOX_X0      32
`define DOV_BOX_Y0      16

`endif

/* hw/debug_overlay_pkg.sv */
`include "debug_overlay_params.svh"

package debug_overlay_pkg;

    // one decimal digit, 0 to 9.
    typedef logic [3:0] bcd_digit_t;

    // index 0 holds the units digit.
    typedef bcd_digit_t [`DOV_DIGITS-1:0] bcd_word_t;

    // one raster pixel with its position.
    typedef struct packed {
        logic                        de;    // data enable.
        logic [`DOV_COORD_WIDTH-1:0] x;
        logic [`DOV_COORD_WIDTH-1:0] y;
        logic [`DOV_PIXEL_WIDTH-1:0] color;
    } pixel_t;

    // glyph position of a pixel inside the box.
    typedef struct packed {
        logic       in_box; // pixel gets overlaid.
        logic [2:0] slot;   // 0 is the leftmost digit.
        logic [2:0] col;    // 0 is the leftmost glyph column.
    } glyph_sel_t;

endpackage

/* hw/overlay_front.sv */
`include "debug_overlay_params.svh"

module overlay_front (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          value_load,
    input  logic [`DOV_VALUE_WIDTH-1:0]   value,
    input  logic                          overlay_en,
    input  debug_overlay_pkg::pixel_t     pix_in,
    output debug_overlay_pkg::bcd_word_t  bcd,
    output logic [2:0]                    font_row,
    output debug_overlay_pkg::pixel_t     stage_pix,
    output debug_overlay_pkg::glyph_sel_t stage_sel
);

    localparam int SHIFT_W = `DOV_VALUE_WIDTH + 4 * `DOV_DIGITS;
    localparam logic [`DOV_COORD_WIDTH-1:0] BOX_X0 = `DOV_BOX_X0;
    localparam logic [`DOV_COORD_WIDTH-1:0] BOX_Y0 = `DOV_BOX_Y0;
    localparam logic [`DOV_COORD_WIDTH-1:0] BOX_W = `DOV_DIGITS * `DOV_GLYPH_W;
    localparam logic [`DOV_COORD_WIDTH-1:0] BOX_H = `DOV_GLYPH_W;

    logic [`DOV_VALUE_WIDTH-1:0]   value_q;
    debug_overlay_pkg::bcd_word_t  bcd_next;
    logic [`DOV_COORD_WIDTH-1:0]   dx;
    logic [`DOV_COORD_WIDTH-1:0]   dy;
    debug_overlay_pkg::glyph_sel_t sel_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            value_q <= '0;
            bcd     <= '0;
        end else begin
            if (value_load) begin
                value_q <= value;
            end
            bcd <= bcd_next; // stable for all digit lookups.
        end
    end

    // double dabble with the digits above the binary part.
    always_comb begin
        logic [SHIFT_W-1:0] sh;
        sh = '0;
        sh[`DOV_VALUE_WIDTH-1:0] = value_q;
        for (int i = 0; i < `DOV_VALUE_WIDTH; i++) begin
            for (int j = 0; j < `DOV_DIGITS; j++) begin
                if (sh[`DOV_VALUE_WIDTH + 4*j +: 4] >= 4'd5) begin
                    sh[`DOV_VALUE_WIDTH + 4*j +: 4] = sh[`DOV_VALUE_WIDTH + 4*j +: 4] + 4'd3;
                end
            end
            sh = sh << 1;
        end
        bcd_next = sh[SHIFT_W-1 -: 4*`DOV_DIGITS];
    end

    assign dx = pix_in.x - BOX_X0; // wraps when left of the box.
    assign dy = pix_in.y - BOX_Y0;

    always_comb begin
        sel_next.in_box = overlay_en && pix_in.de
                       && (pix_in.x >= BOX_X0) && (dx < BOX_W)
                       && (pix_in.y >= BOX_Y0) && (dy < BOX_H);
        sel_next.slot   = dx[5:3]; // offset divided by glyph width.
        sel_next.col    = dx[2:0];
    end

    always_ff @(posedge clk) begin
        stage_pix <= pix_in;
        stage_sel <= sel_next;
        font_row  <= 3'd7 - dy[2:0]; // row 7 is the top line.
        if (rst) begin
            stage_pix.de     <= 1'b0;
            stage_sel.in_box <= 1'b0;
        end
    end

    genvar d;
    generate
        for (d = 0; d < `DOV_DIGITS; d++) begin : g_bcd_chk
            a_bcd_digit: assert property (@(posedge clk) disable iff (rst) bcd[d] <= 4'd9)
                else $error("bcd digit %0d out of range", d);
        end
    endgenerate

endmodule

/* hw/glyph_row_rom.sv */
module glyph_row_rom (
    input  logic                          clk,
    input  logic                          rst,
    input  debug_overlay_pkg::bcd_digit_t digit,
    input  logic [2:0]                    row,
    output logic [7:0]                    bitmap_row
);

    logic [7:0] row_bits;

    // msb is the leftmost pixel, row 7 the top line.
    always_comb begin
        case (digit)
            4'd0: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000010;
                3'd5: row_bits = 8'b01000110;
                3'd4: row_bits = 8'b01001010;
                3'd3: row_bits = 8'b01010010;
                3'd2: row_bits = 8'b01100010;
                3'd1: row_bits = 8'b01000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            4'd1: case (row)
                3'd7: row_bits = 8'b00011000;
                3'd6: row_bits = 8'b00101000;
                3'd5: row_bits = 8'b01001000;
                3'd4: row_bits = 8'b00001000;
                3'd3: row_bits = 8'b00001000;
                3'd2: row_bits = 8'b00001000;
                3'd1: row_bits = 8'b00001000;
                3'd0: row_bits = 8'b01111110;
            endcase
            4'd2: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000010;
                3'd5: row_bits = 8'b00000010;
                3'd4: row_bits = 8'b00000100;
                3'd3: row_bits = 8'b00001000;
                3'd2: row_bits = 8'b00010000;
                3'd1: row_bits = 8'b00100000;
                3'd0: row_bits = 8'b01111110;
            endcase
            4'd3: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000010;
                3'd5: row_bits = 8'b00000010;
                3'd4: row_bits = 8'b00011100;
                3'd3: row_bits = 8'b00000010;
                3'd2: row_bits = 8'b00000010;
                3'd1: row_bits = 8'b01000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            4'd4: case (row)
                3'd7: row_bits = 8'b00000100;
                3'd6: row_bits = 8'b00001100;
                3'd5: row_bits = 8'b00010100;
                3'd4: row_bits = 8'b00100100;
                3'd3: row_bits = 8'b01000100;
                3'd2: row_bits = 8'b01111110;
                3'd1: row_bits = 8'b00000100;
                3'd0: row_bits = 8'b00000100;
            endcase
            4'd5: case (row)
                3'd7: row_bits = 8'b01111110;
                3'd6: row_bits = 8'b01000000;
                3'd5: row_bits = 8'b01000000;
                3'd4: row_bits = 8'b01111100;
                3'd3: row_bits = 8'b00000010;
                3'd2: row_bits = 8'b00000010;
                3'd1: row_bits = 8'b01000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            4'd6: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000000;
                3'd5: row_bits = 8'b01000000;
                3'd4: row_bits = 8'b01111100;
                3'd3: row_bits = 8'b01000010;
                3'd2: row_bits = 8'b01000010;
                3'd1: row_bits = 8'b01000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            4'd7: case (row)
                3'd7: row_bits = 8'b01111110;
                3'd6: row_bits = 8'b00000010;
                3'd5: row_bits = 8'b00000100;
                3'd4: row_bits = 8'b00001000;
                3'd3: row_bits = 8'b00010000;
                3'd2: row_bits = 8'b00010000;
                3'd1: row_bits = 8'b00010000;
                3'd0: row_bits = 8'b00010000;
            endcase
            4'd8: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000010;
                3'd5: row_bits = 8'b01000010;
                3'd4: row_bits = 8'b00111100;
                3'd3: row_bits = 8'b01000010;
                3'd2: row_bits = 8'b01000010;
                3'd1: row_bits = 8'b01000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            4'd9: case (row)
                3'd7: row_bits = 8'b00111100;
                3'd6: row_bits = 8'b01000010;
                3'd5: row_bits = 8'b01000010;
                3'd4: row_bits = 8'b00111110;
                3'd3: row_bits = 8'b00000010;
                3'd2: row_bits = 8'b00000010;
                3'd1: row_bits = 8'b00000010;
                3'd0: row_bits = 8'b00111100;
            endcase
            default: row_bits = 8'b00000000; // not a decimal digit.
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bitmap_row <= 8'b00000000;
        end else begin
            bitmap_row <= row_bits;
        end
    end

endmodule

/* hw/overlay_mixer.sv */
`include "debug_overlay_params.svh"

module overlay_mixer (
    input  logic                          clk,
    input  logic                          rst,
    input  debug_overlay_pkg::pixel_t     stage_pix,
    input  debug_overlay_pkg::glyph_sel_t stage_sel,
    input  logic [`DOV_DIGITS-1:0][7:0]   glyph_rows,
    output debug_overlay_pkg::pixel_t     pix_out
);

    debug_overlay_pkg::pixel_t     pix_d;
    debug_overlay_pkg::glyph_sel_t sel_d;
    logic [2:0]                    digit_idx;
    logic [7:0]                    row_bits;
    logic                          glyph_bit;

    // lines up with the registered glyph rows.
    always_ff @(posedge clk) begin
        pix_d <= stage_pix;
        sel_d <= stage_sel;
        if (rst) begin
            pix_d.de     <= 1'b0;
            sel_d.in_box <= 1'b0;
        end
    end

    assign digit_idx = 3'(`DOV_DIGITS - 1) - sel_d.slot; // slot 0 is the top digit.
    assign row_bits  = glyph_rows[digit_idx];
    assign glyph_bit = row_bits[3'd7 - sel_d.col];

    always_ff @(posedge clk) begin
        pix_out <= pix_d;
        if (sel_d.in_box) begin
            pix_out.color <= glyph_bit ? {`DOV_PIXEL_WIDTH{1'b0}}  // black ink.
                                       : {`DOV_PIXEL_WIDTH{1'b1}}; // white box.
        end
        if (rst) begin
            pix_out.de <= 1'b0;
        end
    end

    // the front decode only flags slots that have a digit.
    a_slot_range: assert property (@(posedge clk) disable iff (rst)
        sel_d.in_box |-> (sel_d.slot < 3'(`DOV_DIGITS)))
        else $error("in-box pixel with slot %0d", sel_d.slot);

endmodule

/* hw/debug_overlay_top.sv */
`include "debug_overlay_params.svh"

module debug_overlay_top (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        value_load,
    input  logic [`DOV_VALUE_WIDTH-1:0] value,
    input  logic                        overlay_en,
    input  debug_overlay_pkg::pixel_t   pix_in,
    output debug_overlay_pkg::pixel_t   pix_out
);

    debug_overlay_pkg::bcd_word_t  bcd;
    logic [2:0]                    font_row;
    debug_overlay_pkg::pixel_t     stage_pix;
    debug_overlay_pkg::glyph_sel_t stage_sel;
    logic [`DOV_DIGITS-1:0][7:0]   glyph_rows; // one row per digit, stage 2.

    overlay_front u_front (
        .clk        (clk),
        .rst        (rst),
        .value_load (value_load),
        .value      (value),
        .overlay_en (overlay_en),
        .pix_in     (pix_in),
        .bcd        (bcd),
        .font_row   (font_row),
        .stage_pix  (stage_pix),
        .stage_sel  (stage_sel)
    );

    genvar d;
    generate
        for (d = 0; d < `DOV_DIGITS; d++) begin : g_digit
            glyph_row_rom u_rom (
                .clk        (clk),
                .rst        (rst),
                .digit      (bcd[d]),
                .row        (font_row),
                .bitmap_row (glyph_rows[d])
            );
        end
    endgenerate

    overlay_mixer u_mixer (
        .clk        (clk),
        .rst        (rst),
        .stage_pix  (stage_pix),
        .stage_sel  (stage_sel),
        .glyph_rows (glyph_rows),
        .pix_out    (pix_out)
    );

endmodule

/* verif/font_ref.svh */
`ifndef FONT_REF_SVH
`define FONT_REF_SVH

// one byte per line, top line in the upper byte, msb leftmost.
function automatic logic [63:0] font_glyph(input int digit);
    case (digit)
        0: font_glyph = 64'h3C42_464A_5262_423C;
        1: font_glyph = 64'h1828_4808_0808_087E;
        2: font_glyph = 64'h3C42_0204_0810_207E;
        3: font_glyph = 64'h3C42_021C_0202_423C;
        4: font_glyph = 64'h040C_1424_447E_0404;
        5: font_glyph = 64'h7E40_407C_0202_423C;
        6: font_glyph = 64'h3C40_407C_4242_423C;
        7: font_glyph = 64'h7E02_0408_1010_1010;
        8: font_glyph = 64'h3C42_423C_4242_423C;
        9: font_glyph = 64'h3C42_423E_0202_023C;
        default: font_glyph = 64'h0;
    endcase
endfunction

// row 7 is the top line, col 0 the leftmost pixel.
function automatic logic font_bit(input int digit, input int row, input int col);
    logic [63:0] glyph;
    glyph    = font_glyph(digit);
    font_bit = glyph[8 * row + 7 - col];
endfunction

`endif

/* verif/debug_overlay_tb.sv */
`include "debug_overlay_params.svh"

module debug_overlay_tb;

    `include "font_ref.svh"

    typedef struct packed {
        logic [`DOV_VALUE_WIDTH-1:0] value;
        logic                        en;
        debug_overlay_pkg::pixel_t   pix;
    } stim_t;

    localparam int X0 = `DOV_BOX_X0;
    localparam int Y0 = `DOV_BOX_Y0;
    localparam int BOX_W = `DOV_DIGITS * `DOV_GLYPH_W;
    localparam int FIXED_LEN = 12;
    localparam int TABLE_LEN = 32;
    localparam int BURST_LEN = BOX_W + 4; // two pixels either side of the box.
    localparam int BURST_NVALS = 6;
    localparam int BURST_ROWS = BURST_NVALS * 10;
    localparam int RUN_CYCLES = TABLE_LEN * 8 + BURST_ROWS * (BURST_LEN + 8) + 16;
    localparam logic [BURST_NVALS-1:0][15:0] BURST_VALS = {
        16'd8, 16'd40960, 16'd12345, 16'd65535, 16'd7, 16'd0
    };

    logic                        clk;
    logic                        rst;
    logic                        value_load;
    logic [`DOV_VALUE_WIDTH-1:0] value;
    logic                        overlay_en;
    debug_overlay_pkg::pixel_t   pix_in;
    debug_overlay_pkg::pixel_t   pix_out;

    stim_t stim_tab [TABLE_LEN];
    int    seed = 32'h6e9b_5267;
    int    errors = 0;
    int    checks = 0;

    debug_overlay_top u_debug_overlay_top (
        .clk        (clk),
        .rst        (rst),
        .value_load (value_load),
        .value      (value),
        .overlay_en (overlay_en),
        .pix_in     (pix_in),
        .pix_out    (pix_out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #((RUN_CYCLES + 20) * 4);
        $display("timeout: the pixel checks did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic stim_t make_stim(input logic [15:0] v, input logic en, input logic de,
                                        input int dx, input int dy, input logic [11:0] color);
        stim_t s;
        s.value     = v;
        s.en        = en;
        s.pix.de    = de;
        s.pix.x     = X0 + dx;
        s.pix.y     = Y0 + dy;
        s.pix.color = color;
        return s;
    endfunction

    // expected pixel from the overlay rules and the reference font.
    function automatic debug_overlay_pkg::pixel_t expected_pixel(
        input logic [15:0] v, input logic en, input debug_overlay_pkg::pixel_t pix);
        debug_overlay_pkg::pixel_t want;
        int dx;
        int dy;
        int slot;
        int divisor;
        int digit;
        want = pix;
        dx   = int'(pix.x) - X0;
        dy   = int'(pix.y) - Y0;
        if (en && pix.de && dx >= 0 && dx < BOX_W && dy >= 0 && dy < 8) begin
            slot    = dx / 8;
            divisor = 1;
            for (int k = 0; k < 4 - slot; k++) begin
                divisor = divisor * 10;
            end
            digit      = (int'(v) / divisor) % 10; // slot 0 is the ten-thousands digit.
            want.color = font_bit(digit, 7 - dy, dx % 8) ? '0 : '1;
        end
        return want;
    endfunction

    task automatic check_pixel(input debug_overlay_pkg::pixel_t want,
                               input debug_overlay_pkg::pixel_t got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %0t pix_out expected %h got %h", $time, want, got);
        end
    endtask

    task automatic check_de(input logic want, input logic got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("Fail %0t pix_out.de expected %b got %b", $time, want, got);
        end
    endtask

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic load_value(input logic [15:0] v);
        value      = v;
        value_load = 1'b1;
        next_cycle();
        value_load = 1'b0;
        next_cycle(); // capture, then bcd register.
        next_cycle();
    endtask

    task automatic apply_entry(input stim_t s);
        overlay_en = s.en;
        load_value(s.value);
        pix_in = s.pix;
        next_cycle();
        pix_in.de = 1'b0;
        next_cycle();
        next_cycle();
        check_pixel(expected_pixel(s.value, s.en, s.pix), pix_out);
    endtask

    // one raster row on consecutive cycles with two pixels in flight.
    task automatic burst_row(input logic [15:0] v, input int dy);
        debug_overlay_pkg::pixel_t want_q [BURST_LEN];
        debug_overlay_pkg::pixel_t p;
        overlay_en = 1'b1;
        load_value(v);
        for (int i = 0; i < BURST_LEN + 3; i++) begin
            if (i >= 3) begin
                check_pixel(want_q[i-3], pix_out);
            end
            if (i < BURST_LEN) begin
                p.de      = 1'b1;
                p.x       = X0 - 2 + i;
                p.y       = Y0 + dy;
                p.color   = $random(seed);
                want_q[i] = expected_pixel(v, 1'b1, p);
                pix_in    = p;
            end else begin
                pix_in.de = 1'b0;
            end
            next_cycle();
        end
    endtask

    initial begin
        rst        = 1'b1;
        value_load = 1'b0;
        value      = '0;
        overlay_en = 1'b0;
        pix_in     = '0;
        pix_in.de  = 1'b1; // pixels keep streaming while reset is held.
        stim_tab[0]  = make_stim(16'd12345, 1'b1, 1'b1, 0, 0, 12'h123);
        stim_tab[1]  = make_stim(16'd12345, 1'b1, 1'b1, 39, 7, 12'h456);
        stim_tab[2]  = make_stim(16'd0, 1'b1, 1'b1, 20, 3, 12'h789);
        stim_tab[3]  = make_stim(16'd7, 1'b1, 1'b1, 35, 0, 12'habc);
        stim_tab[4]  = make_stim(16'd65535, 1'b1, 1'b1, 10, 4, 12'h0f0);
        stim_tab[5]  = make_stim(16'd40960, 1'b1, 1'b1, 17, 2, 12'h5a5);
        stim_tab[6]  = make_stim(16'd12345, 1'b1, 1'b1, -1, 3, 12'h321);
        stim_tab[7]  = make_stim(16'd12345, 1'b1, 1'b1, BOX_W, 3, 12'h654);
        stim_tab[8]  = make_stim(16'd12345, 1'b1, 1'b1, 5, -1, 12'h987);
        stim_tab[9]  = make_stim(16'd12345, 1'b1, 1'b1, 5, 8, 12'hcba);
        stim_tab[10] = make_stim(16'd12345, 1'b1, 1'b0, 5, 3, 12'h3c3);
        stim_tab[11] = make_stim(16'd12345, 1'b0, 1'b1, 5, 3, 12'hc3c);
        for (int k = FIXED_LEN; k < TABLE_LEN; k++) begin
            stim_tab[k] = make_stim($random(seed), ($random(seed) % 8) != 0,
                                    ($random(seed) % 8) != 0,
                                    -4 + $unsigned($random(seed)) % 48,
                                    -2 + $unsigned($random(seed)) % 12, $random(seed));
        end
        repeat (16) @(posedge clk);
        #1;
        rst       = 1'b0;
        pix_in.de = 1'b0;
        check_de(1'b0, pix_out.de);
        for (int k = 0; k < TABLE_LEN; k++) begin
            apply_entry(stim_tab[k]);
        end
        // every value drawn row by row from one line above to one line below the box.
        for (int vi = 0; vi < BURST_NVALS; vi++) begin
            for (int dy = -1; dy < 9; dy++) begin
                burst_row(BURST_VALS[vi], dy);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* sim.f */
+incdir+hw
+incdir+verif
hw/debug_overlay_pkg.sv
hw/overlay_front.sv
hw/glyph_row_rom.sv
hw/overlay_mixer.sv
hw/debug_overlay_top.sv
verif/debug_overlay_tb.sv
